// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_sensor_ctrl
FILELIST   = list.f
PASS_MSG   = All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: list.f
logic/sensor_pkg.sv
logic/spi_req_if.sv
logic/sensor_pwr_seq.sv
logic/sensor_init_seq.sv
logic/python_spi_master.sv
logic/sensor_ctrl_top.sv
tb/sensor_ctrl_checker.sv
tb/tb_sensor_ctrl.sv

// File: logic/python_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module python_spi_master #(
    parameter int SCK_HALF = 4
) (
    input   var logic   clk72,
    input   var logic   mipi_reset_n,
    spi_req_if.target   req,
    output  var logic   ss_n,
    output  var logic   sck,
    output  var logic   mosi,
    input   var logic   miso
);

    localparam int frame_w      = sensor_pkg::frame_w;
    localparam int data_w       = sensor_pkg::spi_data_w;
    localparam int div_w        = $clog2(SCK_HALF) + 1;
    localparam int cnt_w        = $clog2(frame_w + 1);
    localparam int div_last_i   = SCK_HALF - 1;
    localparam int data_first_i = frame_w - data_w;

    localparam logic [div_w-1:0] div_last   = div_last_i[div_w-1:0];
    localparam logic [cnt_w-1:0] bits_all   = frame_w[cnt_w-1:0];
    localparam logic [cnt_w-1:0] data_first = data_first_i[cnt_w-1:0];

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_shift = 2'd1;
    localparam logic [1:0] st_end   = 2'd2;

    logic   [1:0]               state;
    logic   [div_w-1:0]         div_cnt;
    logic   [cnt_w-1:0]         bit_cnt;
    logic                       tick;
    logic                       is_read;
    sensor_pkg::spi_frame_u     shift_q;
    logic   [data_w-1:0]        rd_cap;

    assign req.ready = (state == st_idle);
    assign req.rdata = rd_cap;

    // half sck period elapsed
    assign tick = (div_cnt == div_last);

    // ------------------------------------------------------------
    //  frame control
    // ------------------------------------------------------------
    always_ff @(posedge clk72 or negedge mipi_reset_n) begin
        if (!mipi_reset_n) begin
            state      <= st_idle;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            is_read    <= 1'b0;
            ss_n       <= 1'b1;
            sck        <= 1'b0;
            mosi       <= 1'b0;
            req.rvalid <= 1'b0;
        end
        else begin
            req.rvalid <= 1'b0;
            case (state)
                st_idle: begin
                    if (req.valid) begin
                        state   <= st_shift;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        is_read <= !req.we;
                        ss_n    <= 1'b0;
                        sck     <= 1'b0;
                        // first bit is the address msb
                        mosi    <= req.addr[sensor_pkg::spi_addr_w-1];
                    end
                end
                st_shift: begin
                    if (!tick) begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                    else begin
                        div_cnt <= '0;
                        if (!sck) begin
                            // rising edge, sensor samples mosi
                            sck     <= 1'b1;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        else if (bit_cnt == bits_all) begin
                            sck        <= 1'b0;
                            ss_n       <= 1'b1;
                            mosi       <= 1'b0;
                            req.rvalid <= is_read;
                            state      <= st_end;
                        end
                        else begin
                            sck  <= 1'b0;
                            mosi <= shift_q.raw[frame_w-2];
                        end
                    end
                end
                st_end: begin
                    // one idle cycle with ss_n high before next accept
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    //  shift and capture registers
    // ------------------------------------------------------------
    always_ff @(posedge clk72) begin
        if ((state == st_idle) && req.valid) begin
            shift_q.f.addr <= req.addr;
            shift_q.f.we   <= req.we;
            shift_q.f.data <= req.wdata;
        end
        else if ((state == st_shift) && tick) begin
            if (!sck && is_read && (bit_cnt >= data_first)) begin
                rd_cap <= {rd_cap[data_w-2:0], miso};
            end
            if (sck) begin
                shift_q.raw <= {shift_q.raw[frame_w-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/sensor_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module sensor_ctrl_top #(
    parameter int STEP_CYCLES = 720,
    parameter int SCK_HALF    = 4
) (
    input   var logic           clk72,
    input   var logic           mipi_reset_n,
    input   var logic           sensor_enable,
    input   var logic           sensor_pgood,
    output  var logic           sensor_pwr_en_vdd18,
    output  var logic           sensor_pwr_en_vdd33,
    output  var logic           sensor_pwr_en_pix,
    output  var logic           python_clk_pll,
    output  var logic           python_reset_n,
    output  var logic           python_ss_n,
    output  var logic           python_sck,
    output  var logic           python_mosi,
    input   var logic           python_miso,
    output  var logic           init_done,
    output  var logic   [15:0]  chip_id
);

    logic sensor_ready;

    spi_req_if u_spi_req ();

    // supplies, pll clock and sensor reset
    sensor_pwr_seq #(
        .STEP_CYCLES    (STEP_CYCLES)
    ) i_pwr_seq (
        .clk72          (clk72),
        .mipi_reset_n   (mipi_reset_n),
        .enable         (sensor_enable),
        .pgood          (sensor_pgood),
        .ready          (sensor_ready),
        .pwr_en_vdd18   (sensor_pwr_en_vdd18),
        .pwr_en_vdd33   (sensor_pwr_en_vdd33),
        .pwr_en_pix     (sensor_pwr_en_pix),
        .clk_pll        (python_clk_pll),
        .sensor_reset_n (python_reset_n)
    );

    // chip id read, then register table
    sensor_init_seq i_init_seq (
        .clk72          (clk72),
        .mipi_reset_n   (mipi_reset_n),
        .ready          (sensor_ready),
        .req            (u_spi_req.initiator),
        .init_done      (init_done),
        .chip_id        (chip_id)
    );

    python_spi_master #(
        .SCK_HALF       (SCK_HALF)
    ) i_spi_master (
        .clk72          (clk72),
        .mipi_reset_n   (mipi_reset_n),
        .req            (u_spi_req.target),
        .ss_n           (python_ss_n),
        .sck            (python_sck),
        .mosi           (python_mosi),
        .miso           (python_miso)
    );

endmodule

`default_nettype wire

// File: logic/sensor_init_seq.sv
`timescale 1ns/1ps
`default_nettype none

module sensor_init_seq (
    input   var logic                               clk72,
    input   var logic                               mipi_reset_n,
    input   var logic                               ready,
    spi_req_if.initiator                            req,
    output  var logic                               init_done,
    output  var logic [sensor_pkg::spi_data_w-1:0]  chip_id
);

    localparam int idx_w  = $clog2(sensor_pkg::init_len);
    localparam int last_i = sensor_pkg::init_len - 1;
    localparam logic [idx_w-1:0] idx_last = last_i[idx_w-1:0];

    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_rd_req  = 3'd1;
    localparam logic [2:0] st_rd_wait = 3'd2;
    localparam logic [2:0] st_wr_req  = 3'd3;
    localparam logic [2:0] st_wr_end  = 3'd4;
    localparam logic [2:0] st_done    = 3'd5;

    logic   [2:0]                               state;
    logic   [idx_w-1:0]                         wr_idx;
    logic   [sensor_pkg::init_entry_w-1:0]      entry;
    logic                                       accepted;

    // ------------------------------------------------------------
    //  request fields
    // ------------------------------------------------------------
    assign entry     = sensor_pkg::init_table[wr_idx];
    assign accepted  = req.valid && req.ready;

    assign req.valid = (state == st_rd_req) || (state == st_wr_req);
    assign req.we    = (state == st_wr_req);
    assign req.addr  = req.we ? entry[sensor_pkg::spi_data_w +: sensor_pkg::spi_addr_w]
                              : sensor_pkg::chip_id_addr;
    assign req.wdata = req.we ? entry[sensor_pkg::spi_data_w-1:0] : '0;

    // ------------------------------------------------------------
    //  sequence
    // ------------------------------------------------------------
    always_ff @(posedge clk72 or negedge mipi_reset_n) begin
        if (!mipi_reset_n) begin
            state     <= st_idle;
            wr_idx    <= '0;
            init_done <= 1'b0;
            chip_id   <= '0;
        end
        else if (!ready) begin
            // sensor gone, start over on the next ready
            state     <= st_idle;
            init_done <= 1'b0;
        end
        else begin
            case (state)
                st_idle: begin
                    wr_idx <= '0;
                    state  <= st_rd_req;
                end
                st_rd_req: begin
                    if (accepted) begin
                        state <= st_rd_wait;
                    end
                end
                st_rd_wait: begin
                    if (req.rvalid) begin
                        chip_id <= req.rdata;
                        state   <= st_wr_req;
                    end
                end
                st_wr_req: begin
                    if (accepted) begin
                        if (wr_idx == idx_last) begin
                            state <= st_wr_end;
                        end
                        else begin
                            wr_idx <= wr_idx + 1'b1;
                        end
                    end
                end
                st_wr_end: begin
                    // master idle again means the last frame is off the wire
                    if (req.ready) begin
                        init_done <= 1'b1;
                        state     <= st_done;
                    end
                end
                st_done: begin
                    init_done <= 1'b1;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/sensor_pkg.sv
`default_nettype none

package sensor_pkg;

    // ------------------------------------------------------------
    //  register access widths
    // ------------------------------------------------------------
    localparam int spi_addr_w    = 9;
    localparam int spi_data_w    = 16;
    localparam int frame_w       = spi_addr_w + 1 + spi_data_w;
    localparam int init_entry_w  = spi_addr_w + spi_data_w;

    // power step timer
    localparam int step_cycles_w = 16;

    // one PYTHON SPI frame, sent msb first
    typedef struct packed {
        logic [spi_addr_w-1:0]  addr;
        logic                   we;
        logic [spi_data_w-1:0]  data;
    } spi_frame_t;

    // same word seen by the shifter and by the field decoder
    typedef union packed {
        logic [frame_w-1:0]     raw;
        spi_frame_t             f;
    } spi_frame_u;

    // ------------------------------------------------------------
    //  bring-up register table
    // ------------------------------------------------------------
    localparam logic [spi_addr_w-1:0] chip_id_addr = 9'd0;

    localparam int init_len = 8;

    // {address, data}, written in this order after the id read
    localparam logic [init_entry_w-1:0] init_table [init_len] = '{
        {9'd32,  16'h2004},
        {9'd20,  16'h0000},
        {9'd17,  16'h2113},
        {9'd26,  16'h2280},
        {9'd27,  16'h3d2d},
        {9'd8,   16'h0000},
        {9'd16,  16'h0003},
        {9'd9,   16'h0000}
    };

endpackage

`default_nettype wire

// File: logic/sensor_pwr_seq.sv
`timescale 1ns/1ps
`default_nettype none

module sensor_pwr_seq #(
    parameter int STEP_CYCLES = 720
) (
    input   var logic   clk72,
    input   var logic   mipi_reset_n,
    input   var logic   enable,
    input   var logic   pgood,
    output  var logic   ready,
    output  var logic   pwr_en_vdd18,
    output  var logic   pwr_en_vdd33,
    output  var logic   pwr_en_pix,
    output  var logic   clk_pll,
    output  var logic   sensor_reset_n
);

    // power level, each one adds one output on top of the previous
    localparam logic [2:0] lvl_off   = 3'd0;
    localparam logic [2:0] lvl_vdd18 = 3'd1;
    localparam logic [2:0] lvl_vdd33 = 3'd2;
    localparam logic [2:0] lvl_pix   = 3'd3;
    localparam logic [2:0] lvl_clk   = 3'd4;
    localparam logic [2:0] lvl_rst   = 3'd5;
    localparam logic [2:0] lvl_ready = 3'd6;

    localparam int step_last_i = STEP_CYCLES - 1;
    localparam logic [sensor_pkg::step_cycles_w-1:0] step_last =
        step_last_i[sensor_pkg::step_cycles_w-1:0];

    logic   [2:0]                           level;
    logic   [2:0]                           level_nxt;
    logic   [sensor_pkg::step_cycles_w-1:0] step_cnt;
    logic                                   step_done;
    logic                                   counting;
    logic                                   pgood_lost;
    logic                                   fault;
    logic                                   up_req;
    logic                                   up_q;

    // supply collapse once the clock is running
    assign pgood_lost = (level >= lvl_clk) && !pgood;
    assign up_req     = enable && !fault && !pgood_lost;
    assign step_done  = (step_cnt == step_last);

    // ------------------------------------------------------------
    //  next level
    // ------------------------------------------------------------
    always_comb begin
        counting  = 1'b0;
        level_nxt = level;
        if (up_req) begin
            // pix level holds until pgood
            counting = (level != lvl_ready) && ((level != lvl_pix) || pgood);
            if (counting && step_done) begin
                level_nxt = level + 3'd1;
            end
        end
        else begin
            counting = (level != lvl_off) && (level <= lvl_clk);
            if (level > lvl_clk) begin
                // ready and sensor reset drop together
                level_nxt = lvl_clk;
            end
            else if (counting && step_done) begin
                level_nxt = level - 3'd1;
            end
        end
    end

    always_ff @(posedge clk72 or negedge mipi_reset_n) begin
        if (!mipi_reset_n) begin
            level          <= lvl_off;
            step_cnt       <= '0;
            up_q           <= 1'b0;
            fault          <= 1'b0;
            pwr_en_vdd18   <= 1'b0;
            pwr_en_vdd33   <= 1'b0;
            pwr_en_pix     <= 1'b0;
            clk_pll        <= 1'b0;
            sensor_reset_n <= 1'b0;
            ready          <= 1'b0;
        end
        else begin
            level <= level_nxt;
            up_q  <= up_req;

            // restart the step timer on every level or direction change
            if (!counting || (level_nxt != level) || (up_req != up_q)) begin
                step_cnt <= '0;
            end
            else begin
                step_cnt <= step_cnt + 1'b1;
            end

            // latched until enable goes low, so no retry loop
            if (!enable) begin
                fault <= 1'b0;
            end
            else if (pgood_lost) begin
                fault <= 1'b1;
            end

            pwr_en_vdd18   <= (level_nxt >= lvl_vdd18);
            pwr_en_vdd33   <= (level_nxt >= lvl_vdd33);
            pwr_en_pix     <= (level_nxt >= lvl_pix);
            clk_pll        <= (level_nxt >= lvl_clk);
            sensor_reset_n <= (level_nxt >= lvl_rst);
            ready          <= (level_nxt == lvl_ready);
        end
    end

endmodule

`default_nettype wire

// File: logic/spi_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// register request channel, sequencer to SPI master
interface spi_req_if;

    logic   [sensor_pkg::spi_addr_w-1:0]    addr;
    logic                                   we;
    logic   [sensor_pkg::spi_data_w-1:0]    wdata;
    logic                                   valid;
    logic                                   ready;

    // read return, one-cycle pulse
    logic   [sensor_pkg::spi_data_w-1:0]    rdata;
    logic                                   rvalid;

    modport initiator (
        output  addr, we, wdata, valid,
        input   ready, rdata, rvalid
    );

    modport target (
        input   addr, we, wdata, valid,
        output  ready, rdata, rvalid
    );

endinterface

`default_nettype wire

// File: tb/sensor_ctrl_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sensor_ctrl_checker (
    input   var logic           clk72,
    input   var logic           mipi_reset_n,
    input   var logic           pgood,
    input   var logic           vdd18,
    input   var logic           vdd33,
    input   var logic           pix,
    input   var logic           clk_pll,
    input   var logic           python_reset_n,
    input   var logic           ss_n,
    input   var logic           sck,
    input   var logic           mosi,
    input   var logic           init_done,
    input   var logic   [15:0]  chip_id,
    input   var logic   [15:0]  expected_id,
    output  int                 errors
);

    logic                                   sck_d;
    logic                                   ss_d;
    logic                                   clk_pll_d;
    logic                                   rst_d;
    logic                                   done_d;
    logic                                   in_reset_d = 1'b0;
    logic   [4:0]                           pwr;
    logic   [4:0]                           pwr_d;
    logic   [sensor_pkg::frame_w-1:0]       shreg;
    logic   [sensor_pkg::init_entry_w-1:0]  exp_entry;
    sensor_pkg::spi_frame_u                 fr;
    int                                     nbits;
    int                                     nframes;
    int                                     err_cnt = 0;

    assign errors = err_cnt;
    assign pwr    = {vdd18, vdd33, pix, clk_pll, python_reset_n};

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        err_cnt++;
    endtask

    task automatic report_violation(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    // ------------------------------------------------------------
    //  frame decode against the expected bring-up order
    // ------------------------------------------------------------
    task automatic check_frame();
        fr.raw = shreg;
        if (nbits != sensor_pkg::frame_w) begin
            report_violation($sformatf("frame ended after %0d sck pulses, expected 26", nbits));
        end
        if (nframes == 0) begin
            if (fr.f.we !== 1'b0) report_mismatch("frame0.we", 32'(fr.f.we), 32'(1'b0));
            if (fr.f.addr !== sensor_pkg::chip_id_addr) begin
                report_mismatch("frame0.addr", 32'(fr.f.addr), 32'(sensor_pkg::chip_id_addr));
            end
        end
        else if (nframes <= sensor_pkg::init_len) begin
            exp_entry = sensor_pkg::init_table[nframes-1];
            if (fr.f.we !== 1'b1) report_mismatch("frame.we", 32'(fr.f.we), 32'(1'b1));
            if (fr.f.addr !== exp_entry[24:16]) begin
                report_mismatch("frame.addr", 32'(fr.f.addr), 32'(exp_entry[24:16]));
            end
            if (fr.f.data !== exp_entry[15:0]) begin
                report_mismatch("frame.data", 32'(fr.f.data), 32'(exp_entry[15:0]));
            end
        end
        else begin
            report_violation("extra SPI frame after the init table");
        end
        nframes++;
    endtask

    always @(posedge clk72) begin
        sck_d      <= sck;
        ss_d       <= ss_n;
        clk_pll_d  <= clk_pll;
        rst_d      <= python_reset_n;
        done_d     <= init_done;
        pwr_d      <= pwr;
        in_reset_d <= !mipi_reset_n;
        if (!mipi_reset_n) begin
            nframes = 0;
            nbits   = 0;
            sck_d   <= 1'b0;
            ss_d    <= 1'b1;
            // reset low for a full cycle already
            if (in_reset_d && ({pwr, sck, mosi, init_done} != '0
                || !ss_n || chip_id != '0)) begin
                report_violation("output not at its reset value while mipi_reset_n is low");
            end
        end
        else begin
            // supplies nest, so rise and fall order follows
            if ((vdd33 && !vdd18) || (pix && !vdd33) || (clk_pll && !pix)
                || (python_reset_n && !clk_pll)) begin
                report_violation("power outputs out of order");
            end
            // one power step at a time
            if ($countones(pwr ^ pwr_d) > 1) begin
                report_violation("two power outputs switched in the same cycle");
            end
            if (clk_pll && !clk_pll_d && !pgood) begin
                report_violation("clk_pll rose without pgood");
            end
            if (python_reset_n && !rst_d) begin
                nframes = 0;
            end
            if (!ss_n && ss_d) begin
                nbits = 0;
                if (!python_reset_n) report_violation("SPI frame started while sensor in reset");
                if (init_done) report_violation("SPI frame started after init_done");
            end
            if (sck && !sck_d) begin
                if (ss_n) report_violation("sck pulse with ss_n high");
                shreg = {shreg[sensor_pkg::frame_w-2:0], mosi};
                nbits++;
            end
            if (ss_n && !ss_d) begin
                check_frame();
            end
            if (init_done && !done_d) begin
                if (nframes != sensor_pkg::init_len + 1) begin
                    report_mismatch("frame_count", 32'(nframes), 32'(sensor_pkg::init_len + 1));
                end
                if (chip_id !== expected_id) begin
                    report_mismatch("chip_id", 32'(chip_id), 32'(expected_id));
                end
            end
            if (!python_reset_n && !rst_d && init_done) begin
                report_violation("init_done still high after power-down");
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_sensor_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sensor_ctrl;

    localparam int STEP_CYCLES  = 40;
    localparam int SCK_HALF     = 3;
    localparam int ROUNDS       = 5;
    localparam int MAX_PG_DELAY = 63;
    localparam int ROUND_CYCLES = 8 * STEP_CYCLES
        + (sensor_pkg::init_len + 1) * 26 * 2 * SCK_HALF + MAX_PG_DELAY;
    localparam int WATCHDOG_CYCLES = 2 * ROUNDS * ROUND_CYCLES;

    logic           clk72;
    logic           mipi_reset_n;
    logic           sensor_enable;
    logic           sensor_pgood = 1'b0;
    logic           python_miso = 1'b0;
    logic           vdd18, vdd33, pix, clk_pll, python_reset_n;
    logic           ss_n, sck, mosi, init_done;
    logic   [15:0]  chip_id;
    logic   [15:0]  sensor_id;
    logic           sck_d = 1'b0;
    integer         seed;
    int             pg_delay;
    int             pg_cnt = 0;
    int             miso_cnt = 0;
    int             fails;
    int             checker_errors;
    int             errs_before;
    int             mode;
    string          mode_name [3] = '{"full bring-up", "random power-down", "mid-run reset"};
    int             round_mode [ROUNDS] = '{0, 1, 2, 1, 0};

    sensor_ctrl_top #(
        .STEP_CYCLES (STEP_CYCLES),
        .SCK_HALF    (SCK_HALF)
    ) i_sensor_ctrl_top (
        .clk72 (clk72), .mipi_reset_n (mipi_reset_n), .sensor_enable (sensor_enable),
        .sensor_pgood (sensor_pgood), .sensor_pwr_en_vdd18 (vdd18),
        .sensor_pwr_en_vdd33 (vdd33), .sensor_pwr_en_pix (pix),
        .python_clk_pll (clk_pll), .python_reset_n (python_reset_n),
        .python_ss_n (ss_n), .python_sck (sck), .python_mosi (mosi),
        .python_miso (python_miso), .init_done (init_done), .chip_id (chip_id)
    );

    sensor_ctrl_checker i_checker (
        .clk72 (clk72), .mipi_reset_n (mipi_reset_n), .pgood (sensor_pgood),
        .vdd18 (vdd18), .vdd33 (vdd33), .pix (pix), .clk_pll (clk_pll),
        .python_reset_n (python_reset_n), .ss_n (ss_n), .sck (sck), .mosi (mosi),
        .init_done (init_done), .chip_id (chip_id), .expected_id (sensor_id),
        .errors (checker_errors)
    );

    initial begin
        clk72 = 1'b0;
        forever #10 clk72 = ~clk72;
    end

    // ------------------------------------------------------------
    //  sensor model, pgood after pix and id on miso
    // ------------------------------------------------------------
    always @(posedge clk72) begin
        if (!pix) begin
            pg_cnt       <= 0;
            sensor_pgood <= 1'b0;
        end
        else if (pg_cnt >= pg_delay) sensor_pgood <= 1'b1;
        else pg_cnt <= pg_cnt + 1;
        sck_d <= sck;
        if (ss_n) miso_cnt <= 0;
        else if (sck && !sck_d) miso_cnt <= miso_cnt + 1;
        // id bits go out during the last 16 rising edges
        python_miso <= (miso_cnt >= 10 && miso_cnt < 26) ? sensor_id[25-miso_cnt] : 1'b0;
    end

    task automatic wait_level(input string name, input logic want);
        int n;
        n = 0;
        while (((name == "init_done") ? init_done : vdd18) !== want && n < ROUND_CYCLES) begin
            @(posedge clk72);
            n++;
        end
        if (n >= ROUND_CYCLES) begin
            $display("%s did not reach %b within %0d cycles", name, want, ROUND_CYCLES);
            fails++;
        end
    endtask

    initial begin
        seed          = 52721;
        fails         = 0;
        mipi_reset_n  = 1'b0;
        sensor_enable = 1'b0;
        sensor_id     = '0;
        pg_delay      = 0;
        repeat (10) @(posedge clk72);
        mipi_reset_n <= 1'b1;
        for (int r = 0; r < ROUNDS; r++) begin
            errs_before = checker_errors + fails;
            mode        = round_mode[r];
            pg_delay    = $unsigned($random(seed)) % (MAX_PG_DELAY + 1);
            sensor_id   = 16'($random(seed));
            @(posedge clk72);
            sensor_enable <= 1'b1;
            if (mode == 0) begin
                wait_level("init_done", 1'b1);
                repeat ($unsigned($random(seed)) % 100) @(posedge clk72);
            end
            else begin
                // somewhere between supply ramp and the end of the table writes
                repeat (6 * STEP_CYCLES + $unsigned($random(seed)) % 1400) @(posedge clk72);
            end
            if (mode == 2) begin
                mipi_reset_n  <= 1'b0;
                sensor_enable <= 1'b0;
                repeat (10) @(posedge clk72);
                mipi_reset_n <= 1'b1;
            end
            sensor_enable <= 1'b0;
            @(posedge clk72);
            wait_level("vdd18", 1'b0);
            $display("test %0d %s: %s", r, mode_name[mode],
                     (checker_errors + fails == errs_before) ? "ok" : "FAILED");
        end
        $display("tests %0d, checker errors %0d, other failures %0d", ROUNDS, checker_errors,
                 fails);
        if (checker_errors + fails == 0) $display("All tests passed");
        else $display("Some tests failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk72);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire
